// ==== common/sfm_acc_pkg.sv ====
// ------------------------------
// Widths, defaults and types shared by the
// softmax accumulator, plus the MAC operation encoding
// ------------------------------

package sfm_acc_pkg;

    // Unsigned integer addends
    localparam int unsigned ADD_WIDTH = 16;

    // Q0.16 rescaling factors
    localparam int unsigned FACTOR_WIDTH = 16;

    localparam int unsigned ACC_WIDTH = 32;

    // Tags wrap and compare modulo 16
    localparam int unsigned TAG_WIDTH = 4;

    localparam int unsigned NUM_STAGES_DEF = 3;
    localparam int unsigned FIFO_DEPTH_DEF = 4;

    typedef enum logic [1:0] {
        OP_ADD   = 2'd0,
        OP_MUL   = 2'd1,
        OP_FMADD = 2'd2
    } mac_op_e;

    typedef logic [ACC_WIDTH-1:0] acc_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;

    // Width of a count that runs from zero up to the pipe depth
    function automatic int unsigned uses_width(input int unsigned num_stages);
        return $clog2(num_stages + 1);
    endfunction

endpackage

// ==== rtl/sfm_tag_fifo.sv ====
// ------------------------------
// Circular-buffer FIFO holding tagged
// addend and factor entries
// ------------------------------

`timescale 1ns/10ps

module sfm_tag_fifo #(
    parameter int unsigned DATA_WIDTH = 20,
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  clear_i,
    input  logic                  push_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    input  logic                  pop_i,
    output logic [DATA_WIDTH-1:0] data_o,
    output logic                  full_o,
    output logic                  empty_o
);

    localparam int unsigned PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(FIFO_DEPTH - 1);

    logic [DATA_WIDTH-1:0] mem_q [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]  rd_ptr_q;
    logic [PTR_WIDTH-1:0]  wr_ptr_q;
    logic [CNT_WIDTH-1:0]  count_q;

    // Depth need not be a power of two
    function automatic logic [PTR_WIDTH-1:0] ptr_next(input logic [PTR_WIDTH-1:0] ptr);
        logic [PTR_WIDTH-1:0] nxt;
        nxt = (ptr == LAST_PTR) ? '0 : ptr + PTR_WIDTH'(1);
        return nxt;
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (clear_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            if (push_i && !pop_i) begin
                count_q <= count_q + CNT_WIDTH'(1);
            end else if (pop_i && !push_i) begin
                count_q <= count_q - CNT_WIDTH'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Head shows up the cycle after its push
    assign data_o  = mem_q[rd_ptr_q];
    assign full_o  = (count_q == CNT_WIDTH'(FIFO_DEPTH));
    assign empty_o = (count_q == '0);

    a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o);

    a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o);

endmodule

// ==== rtl/mac/sfm_mac_pipe.sv ====
// ------------------------------
// Pipelined fixed-point multiply-add with
// tag and valid carried alongside the result
// ------------------------------

`timescale 1ns/10ps

module sfm_mac_pipe
    import sfm_acc_pkg::*;
#(
    parameter int unsigned NUM_STAGES = NUM_STAGES_DEF
) (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    clear_i,
    input  logic    issue_valid_i,
    input  mac_op_e op_i,
    input  acc_t    a_i,
    input  acc_t    b_i,
    input  acc_t    c_i,
    input  tag_t    tag_i,
    output logic    res_valid_o,
    output acc_t    res_o,
    output tag_t    res_tag_o
);

    logic [2*ACC_WIDTH-1:0] prod;
    acc_t                   scaled;
    acc_t                   result;

    logic [NUM_STAGES-1:0]  valid_q;
    acc_t                   data_q [NUM_STAGES];
    tag_t                   tag_q  [NUM_STAGES];

    // Factor sits in the low bits of c_i as Q0.16
    assign prod   = a_i * c_i;
    assign scaled = prod[FACTOR_WIDTH +: ACC_WIDTH];

    always_comb begin
        case (op_i)
            OP_MUL:   result = scaled;
            OP_FMADD: result = scaled + b_i;
            default:  result = a_i + b_i;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (clear_i) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= issue_valid_i;
            for (int i = 1; i < NUM_STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Result computed up front, then delayed to the full depth
    always_ff @(posedge clk_i) begin
        data_q[0] <= result;
        tag_q[0]  <= tag_i;
        for (int i = 1; i < NUM_STAGES; i++) begin
            data_q[i] <= data_q[i-1];
            tag_q[i]  <= tag_q[i-1];
        end
    end

    assign res_valid_o = valid_q[NUM_STAGES-1];
    assign res_o       = data_q[NUM_STAGES-1];
    assign res_tag_o   = tag_q[NUM_STAGES-1];

    a_issue_latency : assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        issue_valid_i |-> ##NUM_STAGES res_valid_o);

endmodule

// ==== rtl/sched/sfm_acc_sched.sv ====
// ------------------------------
// Accumulator scheduler: tag and in-flight
// counting, factor use tracking, operand
// selection and the final reduction
// ------------------------------

`timescale 1ns/10ps

module sfm_acc_sched
    import sfm_acc_pkg::*;
#(
    parameter int unsigned NUM_STAGES = NUM_STAGES_DEF,
    localparam int unsigned USES_WIDTH = uses_width(NUM_STAGES)
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    clear_i,
    input  logic                    reduce_i,
    input  logic                    add_take_i,
    input  logic                    mul_take_i,
    input  acc_t                    addend_head_i,
    input  tag_t                    addend_tag_i,
    input  logic                    addend_empty_i,
    input  logic [FACTOR_WIDTH-1:0] factor_head_i,
    input  tag_t                    factor_tag_i,
    input  logic [USES_WIDTH-1:0]   factor_uses_i,
    input  logic                    factor_empty_i,
    input  logic                    res_valid_i,
    input  acc_t                    res_i,
    input  tag_t                    res_tag_i,
    output logic                    addend_pop_o,
    output logic                    factor_pop_o,
    output tag_t                    new_tag_o,
    output logic [USES_WIDTH-1:0]   new_uses_o,
    output logic                    issue_valid_o,
    output mac_op_e                 op_o,
    output acc_t                    a_o,
    output acc_t                    b_o,
    output acc_t                    c_o,
    output tag_t                    issue_tag_o,
    output logic                    acc_valid_o,
    output acc_t                    acc_o
);

    tag_t                  tag_cnt_q;
    logic [USES_WIDTH-1:0] in_flight_q;
    logic [USES_WIDTH-1:0] uses_cnt_q;
    acc_t                  hold_q;
    logic                  hold_valid_q;
    acc_t                  acc_q;
    logic                  acc_valid_q;

    logic reducing;
    logic fac_hit;
    logic add_hit;
    logic start_sum;
    logic last_use;
    logic final_res;
    logic hold_load;
    logic hold_merge;

    assign reducing = reduce_i & addend_empty_i & factor_empty_i;

    // A waiting addend with the same tag goes in before the factor is applied
    assign fac_hit = res_valid_i & ~factor_empty_i & (factor_tag_i == res_tag_i)
                   & ~(~addend_empty_i & (addend_tag_i == res_tag_i));

    // After scaling, the sum expects addends of the next tag
    assign add_hit = res_valid_i & ~addend_empty_i
                   & (addend_tag_i == (fac_hit ? res_tag_i + tag_t'(1) : res_tag_i));

    // Only addends younger than every factor may open a new sum,
    // so each factor's uses value covers all sums it must scale
    assign start_sum = ~res_valid_i & ~addend_empty_i & (addend_tag_i == tag_cnt_q);

    assign last_use = (uses_cnt_q == factor_uses_i - USES_WIDTH'(1));

    assign final_res  = reducing & res_valid_i & ~hold_valid_q
                      & (in_flight_q == USES_WIDTH'(1));
    assign hold_load  = reducing & res_valid_i & ~hold_valid_q & ~final_res;
    assign hold_merge = reducing & res_valid_i & hold_valid_q;

    assign addend_pop_o = add_hit | start_sum;
    // A factor taken with nothing in flight has no sum to scale
    assign factor_pop_o = ~factor_empty_i & ((factor_uses_i == '0) | (fac_hit & last_use));

    assign new_tag_o  = tag_cnt_q + tag_t'(mul_take_i);
    assign new_uses_o = in_flight_q + USES_WIDTH'(start_sum);

    always_comb begin
        issue_valid_o = 1'b0;
        op_o          = OP_ADD;
        a_o           = res_i;
        b_o           = '0;
        c_o           = acc_t'(factor_head_i);
        issue_tag_o   = res_tag_i;
        if (reducing) begin
            issue_valid_o = hold_merge;
            b_o           = hold_q;
        end else if (res_valid_i) begin
            // Sums in flight are always reissued, changed or not
            issue_valid_o = 1'b1;
            if (add_hit) begin
                b_o = addend_head_i;
            end
            if (fac_hit) begin
                op_o        = add_hit ? OP_FMADD : OP_MUL;
                issue_tag_o = res_tag_i + tag_t'(1);
            end
        end else begin
            issue_valid_o = start_sum;
            a_o           = addend_head_i;
            issue_tag_o   = addend_tag_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tag_cnt_q    <= '0;
            in_flight_q  <= '0;
            uses_cnt_q   <= '0;
            hold_valid_q <= 1'b0;
            acc_valid_q  <= 1'b0;
            acc_q        <= '0;
        end else if (clear_i) begin
            tag_cnt_q    <= '0;
            in_flight_q  <= '0;
            uses_cnt_q   <= '0;
            hold_valid_q <= 1'b0;
            acc_valid_q  <= 1'b0;
            acc_q        <= '0;
        end else begin
            if (mul_take_i) begin
                tag_cnt_q <= tag_cnt_q + tag_t'(1);
            end
            if (start_sum) begin
                in_flight_q <= in_flight_q + USES_WIDTH'(1);
            end else if (hold_merge) begin
                in_flight_q <= in_flight_q - USES_WIDTH'(1);
            end else if (final_res) begin
                in_flight_q <= '0;
            end
            if (fac_hit) begin
                uses_cnt_q <= last_use ? '0 : uses_cnt_q + USES_WIDTH'(1);
            end
            if (hold_load) begin
                hold_valid_q <= 1'b1;
            end else if (hold_merge) begin
                hold_valid_q <= 1'b0;
            end
            acc_valid_q <= final_res;
            if (final_res) begin
                acc_q <= res_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (hold_load) begin
            hold_q <= res_i;
        end
    end

    assign acc_valid_o = acc_valid_q;
    assign acc_o       = acc_q;

    // Each sum holds one pipe slot, so the pipe depth bounds the count
    a_in_flight_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_flight_q <= USES_WIDTH'(NUM_STAGES));

    a_uses_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!factor_empty_i && factor_uses_i != '0) |-> (uses_cnt_q < factor_uses_i));

    a_take_when_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
        reducing |-> !add_take_i && !mul_take_i);

endmodule

// ==== rtl/sfm_acc_top.sv ====
// ------------------------------
// Softmax accumulator top: addend and
// factor FIFOs, scheduler and MAC pipe
// ------------------------------

`timescale 1ns/10ps

module sfm_acc_top
    import sfm_acc_pkg::*;
#(
    parameter int unsigned NUM_STAGES = NUM_STAGES_DEF,
    parameter int unsigned FIFO_DEPTH = FIFO_DEPTH_DEF
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    clear_i,
    input  logic                    add_valid_i,
    input  logic [ADD_WIDTH-1:0]    add_i,
    input  logic                    mul_valid_i,
    input  logic [FACTOR_WIDTH-1:0] mul_i,
    input  logic                    reduce_i,
    output logic                    ready_o,
    output logic                    acc_valid_o,
    output acc_t                    acc_o
);

    localparam int unsigned USES_WIDTH     = uses_width(NUM_STAGES);
    localparam int unsigned ADDEND_ENTRY_W = ADD_WIDTH + TAG_WIDTH;
    localparam int unsigned FACTOR_ENTRY_W = FACTOR_WIDTH + TAG_WIDTH + USES_WIDTH;

    logic add_take;
    logic mul_take;

    logic [ADDEND_ENTRY_W-1:0] addend_in;
    logic [ADDEND_ENTRY_W-1:0] addend_out;
    logic                      addend_pop;
    logic                      addend_full;
    logic                      addend_empty;
    acc_t                      addend_head;
    tag_t                      addend_tag;

    logic [FACTOR_ENTRY_W-1:0] factor_in;
    logic [FACTOR_ENTRY_W-1:0] factor_out;
    logic                      factor_pop;
    logic                      factor_full;
    logic                      factor_empty;
    logic [FACTOR_WIDTH-1:0]   factor_head;
    tag_t                      factor_tag;
    tag_t                      factor_tag_in;
    logic [USES_WIDTH-1:0]     factor_uses;

    tag_t                  new_tag;
    logic [USES_WIDTH-1:0] new_uses;

    logic    issue_valid;
    mac_op_e op;
    acc_t    op_a;
    acc_t    op_b;
    acc_t    op_c;
    tag_t    issue_tag;
    logic    res_valid;
    acc_t    res;
    tag_t    res_tag;

    // Inputs are refused for the whole reduction
    assign ready_o  = ~(addend_full | factor_full) & ~reduce_i;
    assign add_take = add_valid_i & ready_o;
    assign mul_take = mul_valid_i & ready_o;

    // A factor's tag excludes itself, one below the tag given to addends
    assign factor_tag_in = new_tag - tag_t'(1);

    assign addend_in = {add_i, new_tag};
    assign factor_in = {mul_i, factor_tag_in, new_uses};

    assign addend_head = acc_t'(addend_out[ADDEND_ENTRY_W-1 -: ADD_WIDTH]);
    assign addend_tag  = addend_out[TAG_WIDTH-1:0];
    assign factor_head = factor_out[FACTOR_ENTRY_W-1 -: FACTOR_WIDTH];
    assign factor_tag  = factor_out[USES_WIDTH +: TAG_WIDTH];
    assign factor_uses = factor_out[USES_WIDTH-1:0];

    sfm_tag_fifo #(
        .DATA_WIDTH (ADDEND_ENTRY_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_addend_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .push_i  (add_take),
        .data_i  (addend_in),
        .pop_i   (addend_pop),
        .data_o  (addend_out),
        .full_o  (addend_full),
        .empty_o (addend_empty)
    );

    sfm_tag_fifo #(
        .DATA_WIDTH (FACTOR_ENTRY_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_factor_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .push_i  (mul_take),
        .data_i  (factor_in),
        .pop_i   (factor_pop),
        .data_o  (factor_out),
        .full_o  (factor_full),
        .empty_o (factor_empty)
    );

    sfm_acc_sched #(
        .NUM_STAGES (NUM_STAGES)
    ) u_sched (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .clear_i        (clear_i),
        .reduce_i       (reduce_i),
        .add_take_i     (add_take),
        .mul_take_i     (mul_take),
        .addend_head_i  (addend_head),
        .addend_tag_i   (addend_tag),
        .addend_empty_i (addend_empty),
        .factor_head_i  (factor_head),
        .factor_tag_i   (factor_tag),
        .factor_uses_i  (factor_uses),
        .factor_empty_i (factor_empty),
        .res_valid_i    (res_valid),
        .res_i          (res),
        .res_tag_i      (res_tag),
        .addend_pop_o   (addend_pop),
        .factor_pop_o   (factor_pop),
        .new_tag_o      (new_tag),
        .new_uses_o     (new_uses),
        .issue_valid_o  (issue_valid),
        .op_o           (op),
        .a_o            (op_a),
        .b_o            (op_b),
        .c_o            (op_c),
        .issue_tag_o    (issue_tag),
        .acc_valid_o    (acc_valid_o),
        .acc_o          (acc_o)
    );

    sfm_mac_pipe #(
        .NUM_STAGES (NUM_STAGES)
    ) u_mac (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .clear_i       (clear_i),
        .issue_valid_i (issue_valid),
        .op_i          (op),
        .a_i           (op_a),
        .b_i           (op_b),
        .c_i           (op_c),
        .tag_i         (issue_tag),
        .res_valid_o   (res_valid),
        .res_o         (res),
        .res_tag_o     (res_tag)
    );

endmodule

// ==== verif/sfm_acc_model.svh ====
// ------------------------------
// Reference model for the softmax
// accumulator and its error bound
// ------------------------------

`ifndef SFM_ACC_MODEL_SVH
`define SFM_ACC_MODEL_SVH

real model_sum;
int  model_factors;

function automatic void clear_model();
    model_sum     = 0.0;
    model_factors = 0;
endfunction

// Q0.16 factor, so the raw value is divided by 2^16
function automatic void apply_factor(input logic [15:0] factor);
    real f;
    f             = factor;
    model_sum     = model_sum * (f / 65536.0);
    model_factors = model_factors + 1;
endfunction

function automatic void add_addend(input logic [15:0] addend);
    real a;
    a         = addend;
    model_sum = model_sum + a;
endfunction

// Each factor truncates at most one product per sum in flight
function automatic real error_bound();
    real t;
    t = model_factors * NUM_STAGES;
    return t;
endfunction

// Truncation only loses value, so the result sits at or below the exact sum
function automatic logic within_bound(input acc_t value);
    real v;
    v = value;
    return (v <= model_sum + 1.0e-6) && (v >= model_sum - error_bound() - 1.0e-6);
endfunction

`endif

// ==== verif/tb_sfm_acc.sv ====
// ------------------------------
// Testbench for the softmax accumulator
// with model, assertions and timeout
// ------------------------------

`timescale 1ns/10ps

module tb_sfm_acc
    import sfm_acc_pkg::*;
();

    localparam int unsigned NUM_STAGES = NUM_STAGES_DEF;
    // Three short runs need a few hundred cycles at most
    localparam int MAX_CYCLES = 4000;

    logic                    clk;
    logic                    rst_n;
    logic                    clear;
    logic                    add_valid;
    logic [ADD_WIDTH-1:0]    add_data;
    logic                    mul_valid;
    logic [FACTOR_WIDTH-1:0] mul_data;
    logic                    reduce;
    logic                    ready;
    logic                    acc_valid;
    acc_t                    acc;

    int mismatch_count = 0;
    int error_count    = 0;
    int pulse_count    = 0;
    int cycle_count    = 0;

    `include "sfm_acc_model.svh"

    sfm_acc_top UUT (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .clear_i     (clear),
        .add_valid_i (add_valid),
        .add_i       (add_data),
        .mul_valid_i (mul_valid),
        .mul_i       (mul_data),
        .reduce_i    (reduce),
        .ready_o     (ready),
        .acc_valid_o (acc_valid),
        .acc_o       (acc)
    );

    always #50 clk = ~clk;

    task automatic log_mismatch(input string msg);
        mismatch_count++;
        $display("MISMATCH at time %0t: %s", $time, msg);
    endtask

    task automatic count_error(input string msg);
        error_count++;
        $display("ERROR at time %0t: %s", $time, msg);
    endtask

    // Model follows every accepted input and checks each result
    always @(posedge clk) begin
        if (!rst_n || clear) begin
            clear_model();
            pulse_count = 0;
        end else begin
            if (acc_valid) begin
                pulse_count = pulse_count + 1;
                result_in_range : assert (within_bound(acc))
                    else log_mismatch($sformatf("acc_o is %0d, expected %0.3f less at most %0.1f",
                        acc, model_sum, error_bound()));
            end
            // A factor taken with an addend scales before the addend lands
            if (mul_valid && ready) begin
                apply_factor(mul_data);
            end
            if (add_valid && ready) begin
                add_addend(add_data);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d mismatches and %0d errors",
                cycle_count, mismatch_count, error_count);
            $display("Simulation failed");
            $finish;
        end
    end

    ready_low_in_reduce : assert property (@(posedge clk) disable iff (!rst_n)
        reduce |-> !ready)
        else log_mismatch("ready_o high while reduce_i is high");

    single_cycle_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        acc_valid |=> !acc_valid)
        else log_mismatch("acc_valid_o high for more than one cycle");

    acc_held : assert property (@(posedge clk) disable iff (!rst_n)
        !clear |=> acc_valid || $stable(acc))
        else log_mismatch("acc_o changed without a new result or clear_i");

    // Holds the strobes until the DUT takes them
    task automatic offer(input logic av, input logic [15:0] a, input logic mv,
                         input logic [15:0] m);
        add_valid <= av;
        add_data  <= a;
        mul_valid <= mv;
        mul_data  <= m;
        @(posedge clk);
        while (!ready) begin
            @(posedge clk);
        end
        add_valid <= 1'b0;
        mul_valid <= 1'b0;
    endtask

    task automatic mixed_run(input int n_items, input int max_factors);
        int          nf;
        int          pick;
        logic [15:0] a;
        logic [15:0] m;
        nf = 0;
        for (int i = 0; i < n_items; i++) begin
            pick = $urandom_range(0, 7);
            a    = 16'($urandom_range(0, 255));
            m    = 16'($urandom_range(32768, 65535));
            if (i > 0 && pick < 2 && nf < max_factors) begin
                nf++;
                offer(pick == 0, a, 1'b1, m);
            end else begin
                offer(1'b1, a, 1'b0, 16'd0);
            end
            repeat ($urandom_range(0, 2)) @(posedge clk);
        end
    endtask

    task automatic reduce_run(input logic stray);
        reduce <= 1'b1;
        @(posedge clk);
        // Sent while ready_o is low, so it must not count
        if (stray) begin
            add_valid <= 1'b1;
            add_data  <= 16'd200;
            mul_valid <= 1'b1;
            mul_data  <= 16'h8000;
            @(posedge clk);
            add_valid <= 1'b0;
            mul_valid <= 1'b0;
        end
        while (!acc_valid) begin
            @(posedge clk);
        end
        reduce <= 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        one_pulse : assert (pulse_count == 1)
            else count_error($sformatf("acc_valid_o pulsed %0d times in one reduction",
                pulse_count));
        @(posedge clk);
    endtask

    task automatic clear_state();
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(32'hedc2));
        clk       = 1'b0;
        rst_n     = 1'b0;
        clear     = 1'b0;
        add_valid = 1'b0;
        add_data  = '0;
        mul_valid = 1'b0;
        mul_data  = '0;
        reduce    = 1'b0;
        clear_model();

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        reset_state : assert (ready === 1'b1 && acc_valid === 1'b0)
            else log_mismatch("ready_o or acc_valid_o wrong after reset");
        @(posedge clk);

        // Integer sum only, so the result is exact
        for (int i = 0; i < 20; i++) begin
            offer(1'b1, 16'($urandom_range(0, 255)), 1'b0, 16'd0);
        end
        reduce_run(1'b0);
        clear_state();

        // Rescaled sum with a refused strobe during reduction
        mixed_run(30, 6);
        reduce_run(1'b1);
        clear_state();

        // Second run after a clear
        mixed_run(12, 3);
        reduce_run(1'b0);
        clear_state();

        $display("Checks done with %0d mismatches and %0d errors", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sfm_acc.f ====
+incdir+verif
common/sfm_acc_pkg.sv
rtl/sfm_tag_fifo.sv
rtl/mac/sfm_mac_pipe.sv
rtl/sched/sfm_acc_sched.sv
rtl/sfm_acc_top.sv
verif/tb_sfm_acc.sv

// ==== Bender.yml ====
package:
  name: sfm_acc

sources:
  # Package first, then leaf modules, then the top level
  - common/sfm_acc_pkg.sv
  - rtl/sfm_tag_fifo.sv
  - rtl/mac/sfm_mac_pipe.sv
  - rtl/sched/sfm_acc_sched.sv
  - rtl/sfm_acc_top.sv

  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_sfm_acc.sv
